// ==== Bender.yml ====
package:
  name: elink_loop

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/elink_pkg.sv
      - src/link_tx.sv
      - src/link_rx.sv
      - src/mem_port.sv
      - src/elink_loop.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/elink_loop_tb.sv

// ==== compile.f ====
+incdir+include
src/elink_pkg.sv
src/link_tx.sv
src/link_rx.sv
src/mem_port.sv
src/elink_loop.sv
testbench/elink_loop_tb.sv

// ==== include/elink_settings.svh ====
`ifndef ELINK_SETTINGS_SVH
`define ELINK_SETTINGS_SVH

// ######################################
// Packet and link geometry
// ######################################
`define PACKET_W      104             // Mesh packet width
`define LINK_W        8               // One link beat
`define BEAT_COUNT    13              // Beats per packet
`define BEAT_CNT_W    4               // Holds 0..BEAT_COUNT
`define ADDR_W        32              // Mesh address
`define DATA_W        32              // Data word

// ######################################
// Memory geometry
// ######################################
`define MEM_AW        8               // Word index width
`define MEM_DEPTH     256             // Words in the array
`define MEM_IDX_LSB   2               // Word index starts at dstaddr bit 2

// Field positions inside the mesh packet
`define WRITE_BIT     0               // Single bit
`define DATAMODE_LSB  1               // Bits 2:1
`define CTRLMODE_LSB  3               // Bits 7:3
`define DSTADDR_LSB   8               // Bits 39:8
`define DATA_LSB      40              // Bits 71:40
`define SRCADDR_LSB   72              // Bits 103:72

`endif

// ==== src/elink_loop.sv ====
`timescale 1ns/1ps
`default_nettype none

module elink_loop
   import elink_pkg::*;
(
   input  wire             clk,
   input  wire             arst_n,
   // Requests from the mesh
   input  wire             access_in,
   input  wire packet_t    packet_in,
   output logic            wait_out,
   // Read responses to the mesh
   output logic            access_out,
   output packet_t         packet_out,
   input  wire             wait_in
);

   // Request link
   logic        req_frame;
   link_byte_t  req_data;
   logic        req_link_wait;
   // Memory port intake
   logic        mem_access;
   packet_t     mem_packet;
   logic        mem_wait;
   // Response link
   logic        rsp_access;
   packet_t     rsp_packet;
   logic        rsp_wait;
   logic        rsp_frame;
   link_byte_t  rsp_data;
   logic        rsp_link_wait;

   // ######################################
   // Request path
   // ######################################
   link_tx u_req_tx (
      .clk        (clk),
      .arst_n     (arst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),              // Top level back-pressure
      .link_frame (req_frame),
      .link_data  (req_data),
      .link_wait  (req_link_wait)
   );

   link_rx u_req_rx (
      .clk        (clk),
      .arst_n     (arst_n),
      .link_frame (req_frame),
      .link_data  (req_data),
      .link_wait  (req_link_wait),
      .access_out (mem_access),
      .packet_out (mem_packet),
      .wait_in    (mem_wait)
   );

   // Remote memory
   mem_port u_mem (
      .clk        (clk),
      .arst_n     (arst_n),
      .access_in  (mem_access),
      .packet_in  (mem_packet),
      .wait_out   (mem_wait),
      .access_out (rsp_access),            // Reads only
      .packet_out (rsp_packet),
      .wait_in    (rsp_wait)
   );

   // ######################################
   // Response path
   // ######################################
   link_tx u_rsp_tx (
      .clk        (clk),
      .arst_n     (arst_n),
      .access_in  (rsp_access),
      .packet_in  (rsp_packet),
      .wait_out   (rsp_wait),
      .link_frame (rsp_frame),
      .link_data  (rsp_data),
      .link_wait  (rsp_link_wait)
   );

   link_rx u_rsp_rx (
      .clk        (clk),
      .arst_n     (arst_n),
      .link_frame (rsp_frame),
      .link_data  (rsp_data),
      .link_wait  (rsp_link_wait),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)                // Consumer stall
   );

endmodule

`default_nettype wire

// ==== src/elink_pkg.sv ====
`default_nettype none

package elink_pkg;

`include "elink_settings.svh"

   // ######################################
   // Packet level types
   // ######################################
   typedef logic [`PACKET_W-1:0]   packet_t;     // Full mesh packet
   typedef logic [`ADDR_W-1:0]     addr_t;       // Dst or src address
   typedef logic [`DATA_W-1:0]     data_t;       // Payload word

   // ######################################
   // Link and memory types
   // ######################################
   typedef logic [`LINK_W-1:0]     link_byte_t;  // One beat on the wire
   typedef logic [`BEAT_CNT_W-1:0] beat_cnt_t;   // Beat position in a frame
   typedef logic [`MEM_AW-1:0]     mem_addr_t;   // Memory word index

   // Serializer FSM
   typedef enum logic [1:0] {
      TX_IDLE,                                    // Ready for a packet
      TX_SEND,                                    // Beats on the link
      TX_GAP                                      // One dead cycle after frame
   } tx_state_t;

endpackage

`default_nettype wire

// ==== src/link_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "elink_settings.svh"

module link_rx
   import elink_pkg::*;
(
   input  wire             clk,
   input  wire             arst_n,
   // Link side, frame/wait
   input  wire             link_frame,
   input  wire link_byte_t link_data,
   output logic            link_wait,
   // Mesh side, access/wait
   output logic            access_out,
   output packet_t         packet_out,
   input  wire             wait_in
);

   packet_t    asm_q;                            // Packet under assembly
   beat_cnt_t  cnt_q;                            // Beats seen in this frame
   logic       valid_q;                          // Output register full
   logic       last_beat;                        // Frame ends on this beat

   assign last_beat  = link_frame & (cnt_q == beat_cnt_t'(`BEAT_COUNT - 1));
   assign access_out = valid_q;
   assign link_wait  = valid_q;                 // Hold off the sender until delivered

   // ######################################
   // Beat counter and output valid
   // ######################################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cnt_q   <= '0;
         valid_q <= 1'b0;
      end else begin
         if (link_frame)
            cnt_q <= cnt_q + 1'b1;
         else
            cnt_q <= '0;                        // Idle link rearms count

         if (last_beat)
            valid_q <= 1'b1;                    // Packet complete
         else if (!wait_in)
            valid_q <= 1'b0;                    // Consumer took it
      end
   end

   // ######################################
   // Assembly and output registers
   // ######################################
   // New beats enter at the top, so the first one ends at the bottom
   always_ff @(posedge clk) begin
      if (link_frame)
         asm_q <= {link_data, asm_q[`PACKET_W-1:`LINK_W]};
      if (last_beat)
         packet_out <= {link_data, asm_q[`PACKET_W-1:`LINK_W]}; // Include final beat
   end

endmodule

`default_nettype wire

// ==== src/link_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "elink_settings.svh"

module link_tx
   import elink_pkg::*;
(
   input  wire             clk,
   input  wire             arst_n,
   // Mesh side, access/wait
   input  wire             access_in,
   input  wire packet_t    packet_in,
   output logic            wait_out,
   // Link side, frame/wait
   output logic            link_frame,
   output link_byte_t      link_data,
   input  wire             link_wait
);

   tx_state_t  state_q;                          // Link FSM
   packet_t    shift_q;                          // Beats still to go, LSB first
   beat_cnt_t  cnt_q;                            // Beats already sent
   logic       accept;                           // Packet taken this cycle
   logic       last_beat;                        // Final beat on the wire

   // ######################################
   // Intake and link outputs
   // ######################################
   // Busy while sending or gapping, and no new frame while the far end holds one
   assign wait_out   = (state_q != TX_IDLE) | link_wait;
   assign accept     = access_in & ~wait_out;
   assign last_beat  = (cnt_q == beat_cnt_t'(`BEAT_COUNT - 1));
   assign link_frame = (state_q == TX_SEND);    // High for BEAT_COUNT cycles
   assign link_data  = shift_q[`LINK_W-1:0];    // Low byte goes first

   // ######################################
   // FSM and beat counter
   // ######################################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= TX_IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            TX_IDLE: begin
               cnt_q <= '0;                     // Fresh count per frame
               if (accept)
                  state_q <= TX_SEND;           // First beat next cycle
            end
            TX_SEND: begin
               cnt_q <= cnt_q + 1'b1;
               if (last_beat)
                  state_q <= TX_GAP;
            end
            default: begin
               state_q <= TX_IDLE;              // Gap lasts a single cycle
            end
         endcase
      end
   end

   // Shift register, one byte out per beat
   always_ff @(posedge clk) begin
      if (accept)
         shift_q <= packet_in;                  // Capture whole packet
      else if (state_q == TX_SEND)
         shift_q <= shift_q >> `LINK_W;         // Next byte to the bottom
   end

endmodule

`default_nettype wire

// ==== src/mem_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "elink_settings.svh"

module mem_port
   import elink_pkg::*;
(
   input  wire             clk,
   input  wire             arst_n,
   // Requests in
   input  wire             access_in,
   input  wire packet_t    packet_in,
   output logic            wait_out,
   // Read responses out
   output logic            access_out,
   output packet_t         packet_out,
   input  wire             wait_in
);

   data_t      mem [`MEM_DEPTH];                 // Remote memory words

   logic                                 req_write;    // Write vs read
   logic [`CTRLMODE_LSB-1:`DATAMODE_LSB] req_datamode;
   logic [`DSTADDR_LSB-1:`CTRLMODE_LSB]  req_ctrlmode;
   addr_t      req_dstaddr;
   data_t      req_data;
   addr_t      req_srcaddr;
   mem_addr_t  word_idx;                         // Array index from dstaddr
   packet_t    rsp_packet;                       // Response before registering
   logic       rsp_valid_q;                      // Response pending
   logic       accept;                           // Request taken this cycle

   // ######################################
   // Request decode
   // ######################################
   assign req_write    = packet_in[`WRITE_BIT];
   assign req_datamode = packet_in[`CTRLMODE_LSB-1:`DATAMODE_LSB];
   assign req_ctrlmode = packet_in[`DSTADDR_LSB-1:`CTRLMODE_LSB];
   assign req_dstaddr  = packet_in[`DSTADDR_LSB +: `ADDR_W];
   assign req_data     = packet_in[`DATA_LSB +: `DATA_W];
   assign req_srcaddr  = packet_in[`SRCADDR_LSB +: `ADDR_W];
   assign word_idx     = req_dstaddr[`MEM_IDX_LSB +: `MEM_AW]; // Word aligned

   // Stall only while a response sits unclaimed
   assign access_out = rsp_valid_q;
   assign wait_out   = rsp_valid_q & wait_in;
   assign accept     = access_in & ~wait_out;

   // Read response, addresses swapped
   always_comb begin
      rsp_packet                                    = '0;
      rsp_packet[`WRITE_BIT]                        = 1'b1;         // Response travels as a write
      rsp_packet[`CTRLMODE_LSB-1:`DATAMODE_LSB]     = req_datamode;
      rsp_packet[`DSTADDR_LSB-1:`CTRLMODE_LSB]      = req_ctrlmode;
      rsp_packet[`DSTADDR_LSB +: `ADDR_W]           = req_srcaddr;  // Back to requester
      rsp_packet[`DATA_LSB +: `DATA_W]              = mem[word_idx];
      rsp_packet[`SRCADDR_LSB +: `ADDR_W]           = req_dstaddr;
   end

   // ######################################
   // Response valid
   // ######################################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n)
         rsp_valid_q <= 1'b0;
      else if (accept && !req_write)
         rsp_valid_q <= 1'b1;                   // New read, may replace a taken one
      else if (!wait_in)
         rsp_valid_q <= 1'b0;
   end

   // Array write and response capture
   always_ff @(posedge clk) begin
      if (accept && req_write)
         mem[word_idx] <= req_data;             // Writes are silent
      if (accept && !req_write)
         packet_out <= rsp_packet;
   end

endmodule

`default_nettype wire

// ==== testbench/elink_loop_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "elink_settings.svh"

module elink_loop_tb
   import elink_pkg::*;
();

   localparam int NUM_TESTS = 19;                    // Entries in the stimulus table
   localparam int LIMIT_NS  = NUM_TESTS * 40 * 10 * 4;

   logic       clk;
   logic       arst_n;
   logic       access_in;
   packet_t    packet_in;
   logic       wait_out;
   logic       access_out;
   packet_t    packet_out;
   logic       wait_in;

   string      tb_name  [NUM_TESTS];                 // Test name per entry
   logic       tb_write [NUM_TESTS];                 // 1 for write, 0 for read
   addr_t      tb_dst   [NUM_TESTS];
   data_t      tb_data  [NUM_TESTS];
   addr_t      tb_src   [NUM_TESTS];
   logic       tb_stall [NUM_TESTS];                 // Random wait_in while answering

   data_t      ref_mem [`MEM_DEPTH];                 // Reference copy of the memory
   packet_t    exp_q [$];                            // Responses still due, in order
   int         exp_idx_q [$];                        // Table entry behind each one
   int         seed        = 57396;
   logic       hold_valid  = 1'b0;                   // Response stalled last edge
   packet_t    hold_packet;

   elink_loop u_elink_loop (
      .clk        (clk),
      .arst_n     (arst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   // ######################################
   // Helpers
   // ######################################
   task automatic raise_failure();
      $display("Simulation FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_value(input string name, input packet_t expected, input packet_t actual);
      if (actual !== expected) begin
         $display("[FAIL] %s expected %h actual %h", name, expected, actual);
         raise_failure();
      end
   endtask

   task automatic set_entry(input int idx, input string name, input logic wr,
                            input addr_t dst, input logic stall);
      tb_name[idx]  = name;
      tb_write[idx] = wr;
      tb_dst[idx]   = dst;
      tb_data[idx]  = $random(seed);                 // Payload, ignored on reads
      tb_src[idx]   = 32'hA000_0000 + idx * 256;     // Distinct requester address
      tb_stall[idx] = stall;
   endtask

   function automatic mem_addr_t word_index(input addr_t addr);
      return addr[9:2];                              // Word aligned index into 256 words
   endfunction

   // Request fields from low to high are write, datamode, ctrlmode, dst, data and src
   function automatic packet_t build_request(input int idx);
      logic [4:0] ctrl;
      logic [1:0] mode;
      ctrl = idx[4:0];
      mode = idx[1:0];
      return {tb_src[idx], tb_data[idx], tb_dst[idx], ctrl, mode, tb_write[idx]};
   endfunction

   // Read answer travels as a write with the addresses swapped
   function automatic packet_t expected_response(input int idx);
      logic [4:0] ctrl;
      logic [1:0] mode;
      ctrl = idx[4:0];
      mode = idx[1:0];
      return {tb_dst[idx], ref_mem[word_index(tb_dst[idx])], tb_src[idx], ctrl, mode, 1'b1};
   endfunction

   task automatic apply_entry(input int idx);
      logic accepted;
      @(negedge clk);
      access_in = 1'b1;                              // Held high across entries
      packet_in = build_request(idx);
      accepted  = 1'b0;
      while (!accepted) begin
         @(posedge clk);
         accepted = !wait_out;                       // Transfer on this edge
      end
      if (tb_write[idx]) begin
         ref_mem[word_index(tb_dst[idx])] = tb_data[idx];
      end else begin
         exp_q.push_back(expected_response(idx));
         exp_idx_q.push_back(idx);
      end
   endtask

   // ######################################
   // Clock, watchdog and stimulus
   // ######################################
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      #(LIMIT_NS);
      $display("Watchdog expired after %0d ns, a request or response never completed", LIMIT_NS);
      raise_failure();
   end

   initial begin
      access_in = 1'b0;
      packet_in = '0;
      arst_n    = 1'b0;
      set_entry(0,  "wr_rd_same_wr",  1'b1, 32'h0000_0010, 1'b0);
      set_entry(1,  "wr_rd_same_rd",  1'b0, 32'h0000_0010, 1'b0);
      set_entry(2,  "multi_wr_40",    1'b1, 32'h0000_0040, 1'b0);
      set_entry(3,  "multi_wr_44",    1'b1, 32'h0000_0044, 1'b0);
      set_entry(4,  "multi_wr_80",    1'b1, 32'h0000_0080, 1'b0);
      set_entry(5,  "multi_wr_3fc",   1'b1, 32'h0000_03FC, 1'b0);
      set_entry(6,  "multi_rewr_44",  1'b1, 32'h0000_0044, 1'b0);
      set_entry(7,  "multi_rd_80",    1'b0, 32'h0000_0080, 1'b0);
      set_entry(8,  "multi_rd_44",    1'b0, 32'h0000_0044, 1'b0);
      set_entry(9,  "multi_rd_3fc",   1'b0, 32'h0000_03FC, 1'b0);
      set_entry(10, "multi_rd_40",    1'b0, 32'h0000_0040, 1'b0);
      set_entry(11, "alias_rd_1040",  1'b0, 32'h0000_1040, 1'b0); // Same word as 0x40
      set_entry(12, "stall_wr_200",   1'b1, 32'h0000_0200, 1'b1);
      set_entry(13, "stall_rd_200",   1'b0, 32'h0000_0200, 1'b1);
      set_entry(14, "stall_rd_10",    1'b0, 32'h0000_0010, 1'b1);
      set_entry(15, "stall_rd_80",    1'b0, 32'h0000_0080, 1'b1);
      set_entry(16, "stall_wr_44",    1'b1, 32'h0000_0044, 1'b1);
      set_entry(17, "stall_rd_44",    1'b0, 32'h0000_0044, 1'b1);
      set_entry(18, "final_rd_200",   1'b0, 32'h0000_0200, 1'b0);
      repeat (2) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      for (int i = 0; i < NUM_TESTS; i++)
         apply_entry(i);
      @(negedge clk);
      access_in = 1'b0;
      while (exp_q.size() != 0)
         @(posedge clk);
      repeat (60) @(posedge clk);                    // Room for a stray duplicate
      $display("Simulation PASSED");
      $finish;
   end

   // ######################################
   // Response monitor
   // ######################################
   initial begin
      logic [31:0] rnd;
      wait_in = 1'b0;
      forever begin
         @(negedge clk);
         rnd = $random(seed);
         if (exp_idx_q.size() != 0 && tb_stall[exp_idx_q[0]])
            wait_in = rnd[0] | rnd[1];               // Stall about three cycles in four
         else
            wait_in = 1'b0;
      end
   end

   always @(posedge clk) begin
      packet_t expected;
      int      idx;
      if (arst_n) begin
         if (hold_valid) begin
            if (!access_out) begin
               $display("Response withdrawn while the consumer was still waiting");
               raise_failure();
            end
            check_value("held response", hold_packet, packet_out);
         end
         if (access_out && !wait_in) begin
            if (exp_q.size() == 0) begin
               $display("Unexpected response %h arrived while no read was outstanding",
                        packet_out);
               raise_failure();
            end
            expected = exp_q.pop_front();
            idx      = exp_idx_q.pop_front();
            check_value(tb_name[idx], expected, packet_out);
         end
         hold_valid  = access_out && wait_in;        // Must not move next edge
         hold_packet = packet_out;
      end
   end

endmodule

`default_nettype wire
